// File: hw/bru_pkg.sv
// Shared widths and depths of the branch resolution path.
// A physical index is the architectural number in the high bits and the
// rename copy in the low RB bits. The branch kind is one-hot, high to low
// beq, bne, blt, bge, bltu, bgeu.
`default_nettype none

package bru_pkg;

	localparam int XLEN = 64; // register width

	localparam int ARCH_REGS = 32; // architectural registers x0..x31
	localparam int RB = 2; // bits of the rename copy index
	localparam int RP = 4; // rename copies per architectural register

	// 5 bits of architectural number followed by RB bits of copy
	localparam int PHY_AW = 7;
	localparam int PHY_REGS = ARCH_REGS * RP; // 128 physical registers

	localparam int BR_OP_W = 6; // one-hot branch kind

	// issue word is {br_op, rs1, rs2}
	localparam int ISSUE_INFO_W = BR_OP_W + 2 * PHY_AW; // 20 bits

	// execute word is {br_op, op1, op2}
	localparam int EXEPARAM_W = BR_OP_W + 2 * XLEN; // 134 bits

	localparam int FIFO_DEPTH = 4; // issue queue entries, power of two
	localparam int FIFO_AW = 2; // issue queue pointer width

endpackage

`default_nettype wire

// File: hw/bru_issue_fifo.sv
// In-order issue queue for branch issue words.
// The head is read straight from storage, so a pushed word shows up one
// cycle after the push and never falls through. The caller must not push
// while full or pop while empty.
`default_nettype none

module bru_issue_fifo (
	input  logic CLK,
	input  logic rst_n,

	input  logic push,
	input  logic [bru_pkg::ISSUE_INFO_W-1:0] push_data,
	input  logic pop,

	output logic full,
	output logic empty,
	output logic [bru_pkg::ISSUE_INFO_W-1:0] head
);

	logic [bru_pkg::ISSUE_INFO_W-1:0] mem [bru_pkg::FIFO_DEPTH]; // entry storage
	logic [bru_pkg::FIFO_AW-1:0] wr_ptr; // next slot to write
	logic [bru_pkg::FIFO_AW-1:0] rd_ptr; // slot at the head
	logic [bru_pkg::FIFO_AW:0] count; // one extra bit so full is distinct from empty

	always_ff @(posedge CLK) begin
		if (push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1; // wraps since depth is a power of two
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // both or neither leave occupancy alone
			endcase
		end
	end

	assign full = (count == (bru_pkg::FIFO_AW + 1)'(bru_pkg::FIFO_DEPTH));
	assign empty = (count == '0);
	assign head = mem[rd_ptr];

	a_no_push_full: assert property (
		@(posedge CLK) disable iff (!rst_n)
		push |-> !full
	) else $error("issue queue pushed while full");

	a_no_pop_empty: assert property (
		@(posedge CLK) disable iff (!rst_n)
		pop |-> !empty
	) else $error("issue queue popped while empty");

endmodule

`default_nettype wire

// File: hw/phy_regfile.sv
// Renamed physical register file with its writeback log.
// RP copies per architectural register, one log bit per copy. Reads are
// combinational from registered state, so a writeback shows up one cycle
// later. Architectural register 0 always reads zero and ready.
`default_nettype none

module phy_regfile (
	input  logic CLK,
	input  logic rst_n,

	// rename allocation marks a copy as pending
	input  logic alloc_valid,
	input  logic [bru_pkg::PHY_AW-1:0] alloc_rd,

	// writeback stores the data and marks the copy as written
	input  logic wb_valid,
	input  logic [bru_pkg::PHY_AW-1:0] wb_rd,
	input  logic [bru_pkg::XLEN-1:0] wb_data,

	// read ports
	input  logic [bru_pkg::PHY_AW-1:0] rs1,
	input  logic [bru_pkg::PHY_AW-1:0] rs2,
	output logic [bru_pkg::XLEN-1:0] rs1_data,
	output logic [bru_pkg::XLEN-1:0] rs2_data,
	output logic rs1_ready,
	output logic rs2_ready
);

	logic [bru_pkg::XLEN-1:0] regs [bru_pkg::PHY_REGS]; // register storage
	logic [bru_pkg::PHY_REGS-1:0] wb_log; // 1 means the copy holds its final value
	logic rs1_zero; // rs1 names x0
	logic rs2_zero; // rs2 names x0

	always_ff @(posedge CLK) begin
		if (wb_valid) begin
			regs[wb_rd] <= wb_data;
		end
	end

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			wb_log <= '1; // nothing is pending out of reset
		end else begin
			if (alloc_valid) begin
				wb_log[alloc_rd] <= 1'b0;
			end
			if (wb_valid) begin
				wb_log[wb_rd] <= 1'b1; // later assignment, so writeback wins a clash
			end
		end
	end

	assign rs1_zero = (rs1[bru_pkg::PHY_AW-1:bru_pkg::RB] == '0);
	assign rs2_zero = (rs2[bru_pkg::PHY_AW-1:bru_pkg::RB] == '0);

	assign rs1_data = rs1_zero ? '0 : regs[rs1];
	assign rs2_data = rs2_zero ? '0 : regs[rs2];
	assign rs1_ready = rs1_zero | wb_log[rs1];
	assign rs2_ready = rs2_zero | wb_log[rs2];

	a_no_wb_x0: assert property (
		@(posedge CLK) disable iff (!rst_n)
		wb_valid |-> (wb_rd[bru_pkg::PHY_AW-1:bru_pkg::RB] != '0)
	) else $error("writeback to architectural register 0");

endmodule

`default_nettype wire

// File: hw/bru_issue.sv
// Branch issue stage.
// Holds the queue head until both sources are marked written, then reads
// the operands and registers them toward execute. The execute register
// holds while exe_ready is low, and the queue does not pop then.
`default_nettype none

module bru_issue (
	input  logic CLK,
	input  logic rst_n,

	// issue queue side
	input  logic fifo_empty,
	input  logic [bru_pkg::ISSUE_INFO_W-1:0] fifo_head,
	output logic fifo_pop,

	// register file side
	output logic [bru_pkg::PHY_AW-1:0] rs1,
	output logic [bru_pkg::PHY_AW-1:0] rs2,
	input  logic [bru_pkg::XLEN-1:0] rs1_data,
	input  logic [bru_pkg::XLEN-1:0] rs2_data,
	input  logic rs1_ready,
	input  logic rs2_ready,

	// execute side
	input  logic exe_ready,
	output logic exeparam_valid,
	output logic [bru_pkg::EXEPARAM_W-1:0] exeparam
);

	logic [bru_pkg::BR_OP_W-1:0] br_op; // one-hot branch kind of the head
	logic clear_raw; // head present and both sources written

	// the source indices of the head word go straight to the register file
	assign {br_op, rs1, rs2} = fifo_head;

	assign clear_raw = ~fifo_empty & rs1_ready & rs2_ready;

	// a pop only happens when the execute register can take the new word
	assign fifo_pop = clear_raw & exe_ready;

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			exeparam_valid <= 1'b0;
		end else if (exe_ready) begin
			exeparam_valid <= clear_raw; // drops to 0 when the head is still waiting
		end
	end

	always_ff @(posedge CLK) begin
		if (fifo_pop) begin
			exeparam <= {br_op, rs1_data, rs2_data};
		end
	end

	// decode in execute relies on exactly one kind bit
	a_op_onehot: assert property (
		@(posedge CLK) disable iff (!rst_n)
		fifo_pop |-> $onehot(br_op)
	) else $error("branch kind is not one-hot at issue");

endmodule

`default_nettype wire

// File: hw/bru_execute.sv
// Branch execute unit for BEQ, BNE, BLT, BGE, BLTU and BGEU.
// A result sits in one output register until res_ready takes it, so a new
// word is accepted only when that register is empty or draining.
`default_nettype none

module bru_execute (
	input  logic CLK,
	input  logic rst_n,

	input  logic exeparam_valid,
	input  logic [bru_pkg::EXEPARAM_W-1:0] exeparam,
	output logic exe_ready,

	output logic res_valid,
	output logic res_taken,
	input  logic res_ready
);

	logic beq;
	logic bne;
	logic blt;
	logic bge;
	logic bltu;
	logic bgeu;
	logic [bru_pkg::XLEN-1:0] op1;
	logic [bru_pkg::XLEN-1:0] op2;
	logic eq; // op1 == op2
	logic lt; // signed op1 < op2
	logic ltu; // unsigned op1 < op2
	logic taken;

	assign {beq, bne, blt, bge, bltu, bgeu, op1, op2} = exeparam;

	assign eq = (op1 == op2);
	assign lt = ($signed(op1) < $signed(op2));
	assign ltu = (op1 < op2);

	assign taken = (beq & eq) | (bne & ~eq) |
		(blt & lt) | (bge & ~lt) |
		(bltu & ltu) | (bgeu & ~ltu);

	assign exe_ready = ~res_valid | res_ready;

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			res_valid <= 1'b0;
		end else if (exe_ready) begin
			res_valid <= exeparam_valid; // refill or empty the result register
		end
	end

	always_ff @(posedge CLK) begin
		if (exe_ready && exeparam_valid) begin
			res_taken <= taken;
		end
	end

	a_res_stable: assert property (
		@(posedge CLK) disable iff (!rst_n)
		res_valid && !res_ready |=> res_valid && $stable(res_taken)
	) else $error("result changed while stalled");

endmodule

`default_nettype wire

// File: hw/bru_top.sv
// Branch resolution path: issue queue, issue stage, execute unit and the
// physical register file. A dispatch word is taken only while disp_full is
// low. Results leave in push order, at least three cycles after the push.
`default_nettype none

module bru_top (
	input  logic CLK,
	input  logic rst_n,

	// dispatch
	input  logic disp_valid,
	input  logic [bru_pkg::ISSUE_INFO_W-1:0] disp_info,
	output logic disp_full,

	// rename allocation
	input  logic alloc_valid,
	input  logic [bru_pkg::PHY_AW-1:0] alloc_rd,

	// writeback
	input  logic wb_valid,
	input  logic [bru_pkg::PHY_AW-1:0] wb_rd,
	input  logic [bru_pkg::XLEN-1:0] wb_data,

	// result
	output logic res_valid,
	output logic res_taken,
	input  logic res_ready
);

	wire fifo_push = disp_valid & ~disp_full; // a word offered while full is ignored
	wire fifo_pop;
	wire fifo_empty;
	wire [bru_pkg::ISSUE_INFO_W-1:0] fifo_head;
	wire [bru_pkg::PHY_AW-1:0] rs1;
	wire [bru_pkg::PHY_AW-1:0] rs2;
	wire [bru_pkg::XLEN-1:0] rs1_data;
	wire [bru_pkg::XLEN-1:0] rs2_data;
	wire rs1_ready;
	wire rs2_ready;
	wire exe_ready;
	wire exeparam_valid;
	wire [bru_pkg::EXEPARAM_W-1:0] exeparam;

	bru_issue_fifo u_fifo (
		.CLK(CLK), .rst_n(rst_n),
		.push(fifo_push), .push_data(disp_info), .pop(fifo_pop),
		.full(disp_full), .empty(fifo_empty), .head(fifo_head)
	);

	bru_issue u_issue (
		.CLK(CLK), .rst_n(rst_n),
		.fifo_empty(fifo_empty), .fifo_head(fifo_head), .fifo_pop(fifo_pop),
		.rs1(rs1), .rs2(rs2), .rs1_data(rs1_data), .rs2_data(rs2_data),
		.rs1_ready(rs1_ready), .rs2_ready(rs2_ready),
		.exe_ready(exe_ready), .exeparam_valid(exeparam_valid), .exeparam(exeparam)
	);

	bru_execute u_execute (
		.CLK(CLK), .rst_n(rst_n),
		.exeparam_valid(exeparam_valid), .exeparam(exeparam), .exe_ready(exe_ready),
		.res_valid(res_valid), .res_taken(res_taken), .res_ready(res_ready)
	);

	phy_regfile u_regfile (
		.CLK(CLK), .rst_n(rst_n),
		.alloc_valid(alloc_valid), .alloc_rd(alloc_rd),
		.wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
		.rs1(rs1), .rs2(rs2), .rs1_data(rs1_data), .rs2_data(rs2_data),
		.rs1_ready(rs1_ready), .rs2_ready(rs2_ready)
	);

endmodule

`default_nettype wire

// File: tests/bru_tb.sv
// Testbench for the branch resolution path, replaying tests/bru_cases.txt.
// Run it from the project root so the case file path resolves.
// A register must not be rewritten while a queued branch still reads it,
// except through an alloc followed by a wb.
`default_nettype none

module bru_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int TIMEOUT = 200; // cycles any single wait may take
	localparam int CAPACITY = 6; // queue entries plus the issue and result registers

	logic CLK = 1'b0;
	logic rst_n;
	logic disp_valid;
	logic [bru_pkg::ISSUE_INFO_W-1:0] disp_info;
	logic disp_full;
	logic alloc_valid;
	logic [bru_pkg::PHY_AW-1:0] alloc_rd;
	logic wb_valid;
	logic [bru_pkg::PHY_AW-1:0] wb_rd;
	logic [bru_pkg::XLEN-1:0] wb_data;
	logic res_valid;
	logic res_taken;
	logic res_ready;

	logic [bru_pkg::XLEN-1:0] model_regs [bru_pkg::PHY_REGS]; // values written so far
	logic [bru_pkg::PHY_REGS-1:0] model_log; // expected writeback log
	logic [bru_pkg::ISSUE_INFO_W-1:0] pend_q [$]; // pushed branches not yet checked
	logic got_mem [256]; // taken bits in the order they left the DUT
	logic [7:0] got_wr = 8'd0; // advanced by the monitor only
	logic [7:0] got_rd = 8'd0;
	int n_pushed = 0;
	int n_done = 0;
	int stall_left = 0; // cycles of res_ready low still to come
	logic held_valid = 1'b0; // a result was stalled at the last edge
	logic held_taken = 1'b0;

	always #10 CLK = ~CLK;

	bru_top dut (
		.CLK(CLK), .rst_n(rst_n),
		.disp_valid(disp_valid), .disp_info(disp_info), .disp_full(disp_full),
		.alloc_valid(alloc_valid), .alloc_rd(alloc_rd),
		.wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
		.res_valid(res_valid), .res_taken(res_taken), .res_ready(res_ready)
	);

	task automatic fail_now(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			fail_now($sformatf("[ERROR] t=%0t %s: got %b, expected %b", $time, name, got, exp));
		end
	endtask

	task automatic check_taken(input logic got, input logic exp);
		if (got !== exp) begin
			fail_now($sformatf("[ERROR] t=%0t res_taken: got %b, expected %b", $time, got, exp));
		end
	endtask

	// flop outputs are read before the edge updates them
	always @(posedge CLK) begin
		if (rst_n) begin
			if (held_valid) begin
				check_flag("res_valid", res_valid, 1'b1); // a stalled result must stay put
				check_taken(res_taken, held_taken);
			end
			held_valid = res_valid & ~res_ready;
			held_taken = res_taken;
			if (res_valid && res_ready) begin
				got_mem[got_wr] = res_taken;
				got_wr = got_wr + 8'd1;
				n_done = n_done + 1;
			end
		end
	end

	// all inputs change here, on the falling edge
	task automatic step();
		@(negedge CLK);
		disp_valid = 1'b0; // strobes last a single cycle
		alloc_valid = 1'b0;
		wb_valid = 1'b0;
		if (stall_left > 0) begin
			res_ready = 1'b0;
			stall_left = stall_left - 1;
		end else begin
			res_ready = 1'b1;
		end
	endtask

	function automatic logic source_ready(input logic [bru_pkg::PHY_AW-1:0] phy);
		return (phy[bru_pkg::PHY_AW-1:bru_pkg::RB] == '0) || model_log[phy];
	endfunction

	function automatic logic [bru_pkg::XLEN-1:0] source_value(
			input logic [bru_pkg::PHY_AW-1:0] phy);
		if (phy[bru_pkg::PHY_AW-1:bru_pkg::RB] == '0) begin
			return '0; // every copy of x0 reads zero
		end
		return model_regs[phy];
	endfunction

	function automatic logic head_blocked();
		logic [bru_pkg::ISSUE_INFO_W-1:0] info;
		if (pend_q.size() == 0) begin
			return 1'b0;
		end
		info = pend_q[0];
		return !source_ready(info[2*bru_pkg::PHY_AW-1:bru_pkg::PHY_AW]) ||
			!source_ready(info[bru_pkg::PHY_AW-1:0]);
	endfunction

	// RV64 branch rules, signed order taken from the sign bits first
	function automatic logic branch_taken(input logic [bru_pkg::BR_OP_W-1:0] kind,
			input logic [bru_pkg::XLEN-1:0] a, input logic [bru_pkg::XLEN-1:0] b);
		logic less;
		if (a[bru_pkg::XLEN-1] != b[bru_pkg::XLEN-1]) begin
			less = a[bru_pkg::XLEN-1]; // the negative one is smaller
		end else begin
			less = (a < b);
		end
		case (kind)
			6'b100000: return a == b;
			6'b010000: return a != b;
			6'b001000: return less;
			6'b000100: return !less;
			6'b000010: return a < b;
			6'b000001: return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	task automatic need_fields(input int got, input int want, input string cmd);
		if (got != want) begin
			fail_now($sformatf("case file line for %s has missing fields", cmd));
		end
	endtask

	initial begin
		int fd;
		int code;
		int n;
		string cmd;
		string rest;
		logic [bru_pkg::PHY_AW-1:0] p1;
		logic [bru_pkg::PHY_AW-1:0] p2;
		logic [bru_pkg::BR_OP_W-1:0] kind;
		logic [bru_pkg::XLEN-1:0] data;
		logic bit_exp;
		logic model_bit;
		logic [bru_pkg::ISSUE_INFO_W-1:0] info;

		code = $urandom(33462); // seeds the idle gap lengths
		rst_n = 1'b0;
		disp_valid = 1'b0;
		disp_info = '0;
		alloc_valid = 1'b0;
		alloc_rd = '0;
		wb_valid = 1'b0;
		wb_rd = '0;
		wb_data = '0;
		res_ready = 1'b1;
		model_log = '1;
		repeat (8) step();
		rst_n = 1'b1;
		step();
		check_flag("res_valid", res_valid, 1'b0);
		check_flag("disp_full", disp_full, 1'b0);

		fd = $fopen("tests/bru_cases.txt", "r");
		if (fd == 0) begin
			fail_now("cannot open the case file tests/bru_cases.txt");
		end
		while ($fscanf(fd, "%s", cmd) == 1) begin
			if (cmd.substr(0, 0) == "#") begin
				code = $fgets(rest, fd); // skip the rest of a comment line
			end else if (cmd == "alloc") begin
				need_fields($fscanf(fd, "%h", p1), 1, cmd);
				step();
				alloc_valid = 1'b1;
				alloc_rd = p1;
				model_log[p1] = 1'b0;
			end else if (cmd == "wb") begin
				need_fields($fscanf(fd, "%h %h", p1, data), 2, cmd);
				n = 1 + $urandom % 3;
				repeat (n) begin
					step();
					// nothing may leave while the oldest branch waits on a source
					if (got_wr == got_rd && head_blocked()) begin
						check_flag("res_valid", res_valid, 1'b0);
					end
				end
				wb_valid = 1'b1;
				wb_rd = p1;
				wb_data = data;
				model_regs[p1] = data;
				model_log[p1] = 1'b1;
			end else if (cmd == "push") begin
				need_fields($fscanf(fd, "%b %h %h", kind, p1, p2), 3, cmd);
				if (!$onehot(kind)) begin
					fail_now("case file holds a branch kind that is not one-hot");
				end
				n = $urandom % 3;
				repeat (n) step();
				step();
				n = 0;
				while (disp_full) begin
					if (n >= TIMEOUT) begin
						fail_now("timeout while waiting for disp_full to drop");
					end
					step();
					n = n + 1;
				end
				disp_valid = 1'b1;
				disp_info = {kind, p1, p2};
				pend_q.push_back({kind, p1, p2});
				n_pushed = n_pushed + 1;
				step();
				if (stall_left > 0 && n_pushed - n_done == CAPACITY) begin
					check_flag("disp_full", disp_full, 1'b1); // every stage holds a branch
				end
			end else if (cmd == "stall") begin
				need_fields($fscanf(fd, "%d", n), 1, cmd);
				stall_left = n;
			end else if (cmd == "expect") begin
				need_fields($fscanf(fd, "%b", bit_exp), 1, cmd);
				if (pend_q.size() == 0) begin
					fail_now("case file expects a result without a pushed branch");
				end
				n = 0;
				while (got_wr == got_rd) begin
					if (n >= TIMEOUT) begin
						fail_now("timeout while waiting for a branch result");
					end
					step();
					n = n + 1;
				end
				info = pend_q.pop_front();
				{kind, p1, p2} = info;
				model_bit = branch_taken(kind, source_value(p1), source_value(p2));
				if (model_bit !== bit_exp) begin
					fail_now("case file expectation disagrees with the branch compare rules");
				end
				check_taken(got_mem[got_rd], model_bit);
				got_rd = got_rd + 8'd1;
			end else begin
				fail_now($sformatf("unknown command %s in the case file", cmd));
			end
		end
		$fclose(fd);
		repeat (10) step();
		if (got_wr != got_rd || pend_q.size() != 0) begin
			fail_now("the DUT and the case file disagree on the number of results");
		end else begin
			$display("test passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: tests/bru_cases.txt
# columns: command then fields, physical index and data in hex, kind in binary
# kind bits beq bne blt bge bltu bgeu, expect gives the taken bit, stall gives cycles
wb 04 0000000000000005
wb 08 0000000000000005
wb 0c fffffffffffffffe
wb 10 0000000000000003
wb 14 8000000000000000
push 100000 04 08
push 010000 04 08
push 001000 0c 10
push 000100 0c 10
expect 1
expect 0
expect 1
expect 0
push 000010 0c 10
push 000001 0c 10
push 001000 14 00
push 000010 00 14
push 100000 01 00
expect 0
expect 1
expect 1
expect 1
expect 1
alloc 05
push 100000 05 04
push 010000 08 10
wb 05 0000000000000005
expect 1
expect 1
stall 40
push 100000 04 08
push 010000 04 08
push 001000 0c 10
push 000100 0c 10
push 000010 0c 10
push 000001 0c 10
push 001000 14 0c
expect 1
expect 0
expect 1
expect 0
expect 0
expect 1
expect 1

// File: verilog.f
hw/bru_pkg.sv
hw/bru_issue_fifo.sv
hw/phy_regfile.sv
hw/bru_issue.sv
hw/bru_execute.sv
hw/bru_top.sv
tests/bru_tb.sv

// File: Makefile
# Verilator build and run, invoked from the project root
VERILATOR ?= verilator
TOP ?= bru_tb
FILELIST ?= verilog.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "test passed" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
